// File: build.f
verilog/sya_pkg.sv
verilog/sya_ctrl_if.sv
verilog/sya_pe.sv
verilog/sya_pe_array.sv
verilog/sya_feeder.sv
verilog/sya_ofm_writer.sv
verilog/sya_ctrl.sv
verilog/sya_top.sv
testbench/sya_assertions.sv
testbench/tb_sya.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_sya -f build.f -o Vtb_sya
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_sya > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$log"; then
    exit 1
fi
exit 0

// File: testbench/sya_assertions.sv
// Concurrent protocol assertions on the engine's top level ports
// Handshake hold rules, paired address valids, write and config exclusion
`timescale 1ns/1ps
`default_nettype none

module sya_assertions import sya_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              cfg_rdy,
    input logic [ADDR_W-1:0] act_rd_addr,
    input logic              act_rd_addr_vld,
    input logic              act_rd_addr_rdy,
    input logic [ADDR_W-1:0] wgt_rd_addr,
    input logic              wgt_rd_addr_vld,
    input logic              wgt_rd_addr_rdy,
    input ofm_vec_t          ofm_wr_dat,
    input logic [ADDR_W-1:0] ofm_wr_addr,
    input logic              ofm_wr_vld,
    input logic              ofm_wr_rdy,
    input ctrl_state_t       state
);

    // Address pair waits for both readies
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        act_rd_addr_vld && !(act_rd_addr_rdy && wgt_rd_addr_rdy)
        |=> act_rd_addr_vld && $stable(act_rd_addr) && $stable(wgt_rd_addr))
        else $error("address pair dropped or changed before acceptance");

    a_addr_pair: assert property (@(posedge clk) disable iff (!rst_n)
        act_rd_addr_vld == wgt_rd_addr_vld)
        else $error("address valids differ");

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy
        |=> ofm_wr_vld && $stable(ofm_wr_dat) && $stable(ofm_wr_addr))
        else $error("output write dropped or changed before acceptance");

    a_wr_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld |-> state == S_DRAIN)
        else $error("output write valid outside a drain");

    a_cfg_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (act_rd_addr_vld || wgt_rd_addr_vld || ofm_wr_vld) |-> !cfg_rdy)
        else $error("cfg_rdy high while a job is active");

endmodule

bind sya_top sya_assertions u_assertions (
    .clk             (clk),
    .rst_n           (rst_n),
    .cfg_rdy         (cfg_rdy),
    .act_rd_addr     (act_rd_addr),
    .act_rd_addr_vld (act_rd_addr_vld),
    .act_rd_addr_rdy (act_rd_addr_rdy),
    .wgt_rd_addr     (wgt_rd_addr),
    .wgt_rd_addr_vld (wgt_rd_addr_vld),
    .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
    .ofm_wr_dat      (ofm_wr_dat),
    .ofm_wr_addr     (ofm_wr_addr),
    .ofm_wr_vld      (ofm_wr_vld),
    .ofm_wr_rdy      (ofm_wr_rdy),
    .state           (u_ctrl.state)
);

`default_nettype wire

// File: testbench/tb_sya.sv
// Testbench for the systolic array engine
// Clock, reset, read memory model with LFSR timing, reference model
// Directed tests over single group, multi group, random timing, ignored config
`timescale 1ns/1ps
`default_nettype none

module tb_sya import sya_pkg::*; ();

    localparam int MEM_DEPTH   = 1024;
    localparam int JOB_TIMEOUT = 4000;

    logic              clk;
    logic              rst_n;
    logic              cfg_vld;
    logic              cfg_rdy;
    cfg_t              cfg_info;
    logic [ADDR_W-1:0] act_rd_addr;
    logic              act_rd_addr_vld;
    logic              act_rd_addr_rdy;
    logic [ADDR_W-1:0] wgt_rd_addr;
    logic              wgt_rd_addr_vld;
    logic              wgt_rd_addr_rdy;
    act_vec_t          act_rd_dat;
    logic              act_rd_dat_vld;
    logic              act_rd_dat_rdy;
    wgt_vec_t          wgt_rd_dat;
    logic              wgt_rd_dat_vld;
    logic              wgt_rd_dat_rdy;
    ofm_vec_t          ofm_wr_dat;
    logic [ADDR_W-1:0] ofm_wr_addr;
    logic              ofm_wr_vld;
    logic              ofm_wr_rdy;

    // Memory contents, outstanding reads and logged traffic
    logic [31:0]       act_mem [MEM_DEPTH];
    logic [31:0]       wgt_mem [MEM_DEPTH];
    logic [ADDR_W-1:0] pend_act [$];
    logic [ADDR_W-1:0] pend_wgt [$];
    logic [ADDR_W-1:0] act_log [$];
    logic [ADDR_W-1:0] wgt_log [$];
    logic [ADDR_W-1:0] wr_addr_log [$];
    logic [31:0]       wr_dat_log [$];
    logic [31:0]       lfsr;
    logic [1:0]        dly;
    logic              rand_en;
    logic              rnd;
    logic              timed_out;
    int                n_val_err;
    int                n_oth_err;

    sya_top i_dut (.*);

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_val_err++;
        $display("error: %s = %0h, expected %0h", name, got, exp);
    endtask

    task automatic other_error(input string msg);
        n_oth_err++;
        $display("%0d ns: %s", $time, msg);
    endtask

    task automatic timeout(input string what);
        other_error({"timeout while waiting for ", what});
        timed_out = 1'b1;
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    // ========================================================================
    // Memory model
    // ========================================================================
    always @(posedge clk) begin
        rnd = rand_en;
        if (rst_n) begin
            if (act_rd_addr_vld && act_rd_addr_rdy && wgt_rd_addr_rdy) begin
                if (act_rd_addr >= MEM_DEPTH || wgt_rd_addr >= MEM_DEPTH) begin
                    other_error("read address outside the memory model");
                end
                act_log.push_back(act_rd_addr);
                wgt_log.push_back(wgt_rd_addr);
                pend_act.push_back(act_rd_addr);
                pend_wgt.push_back(wgt_rd_addr);
            end
            // Beats leave in address order
            if (act_rd_dat_vld && act_rd_dat_rdy && wgt_rd_dat_rdy && pend_act.size() > 0) begin
                pend_act.delete(0);
                pend_wgt.delete(0);
                dly = rnd ? 2'(lfsr_bits(2)) : 2'd0;
            end else if (dly != 0) begin
                dly = dly - 2'd1;
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                wr_addr_log.push_back(ofm_wr_addr);
                wr_dat_log.push_back(ofm_wr_dat);
            end
        end
        #1;
        act_rd_addr_rdy = rnd ? 1'(lfsr_bits(1)) : 1'b1;
        wgt_rd_addr_rdy = rnd ? 1'(lfsr_bits(1)) : 1'b1;
        ofm_wr_rdy      = rnd ? 1'(lfsr_bits(1)) : 1'b1;
        if (pend_act.size() > 0 && dly == 0) begin
            act_rd_dat     = act_mem[pend_act[0]];
            wgt_rd_dat     = wgt_mem[pend_wgt[0]];
            act_rd_dat_vld = 1'b1;
            wgt_rd_dat_vld = 1'b1;
        end else begin
            act_rd_dat_vld = 1'b0;
            wgt_rd_dat_vld = 1'b0;
        end
    end

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic cfg_t make_cfg(input int act_base, input int wgt_base,
                                      input int ofm_base, input int num_grp,
                                      input int chn, input int shift, input int zp);
        cfg_t c;
        c.act_base = ADDR_W'(act_base);
        c.wgt_base = ADDR_W'(wgt_base);
        c.ofm_base = ADDR_W'(ofm_base);
        c.num_grp  = GRP_W'(num_grp);
        c.chn      = CHN_W'(chn);
        c.shift    = SHIFT_W'(shift);
        c.zp       = ACT_W'(zp);
        return c;
    endfunction

    // Dot product over the group's channels followed by ReLU and requantization
    function automatic logic [31:0] expected_row(input cfg_t c, input int g, input int r);
        logic [31:0] row;
        logic [31:0] a_word;
        logic [31:0] w_word;
        int          sum;
        row = '0;
        for (int col = 0; col < NUM_COL; col++) begin
            sum = 0;
            for (int k = 0; k < int'(c.chn); k++) begin
                a_word = act_mem[int'(c.act_base) + g * int'(c.chn) + k];
                w_word = wgt_mem[int'(c.wgt_base) + k];
                sum += int'($signed(a_word[8*r +: 8])) * int'($signed(w_word[8*col +: 8]));
            end
            if (sum >= 0) begin
                row[8*col +: 8] = 8'((sum >> c.shift) + int'(c.zp));
            end
        end
        return row;
    endfunction

    task automatic check_job(input cfg_t c);
        int                n_rd;
        int                n_wr;
        logic [ADDR_W-1:0] exp_addr;
        logic [31:0]       exp_dat;
        n_rd = int'(c.num_grp) * int'(c.chn);
        n_wr = int'(c.num_grp) * NUM_ROW;
        if (act_log.size() != n_rd) begin
            other_error($sformatf("%0d address pairs accepted, %0d expected",
                                  act_log.size(), n_rd));
        end
        for (int i = 0; i < n_rd && i < act_log.size(); i++) begin
            exp_addr = ADDR_W'(int'(c.act_base) + i);
            if (act_log[i] !== exp_addr) value_error("act_rd_addr", act_log[i], exp_addr);
            exp_addr = ADDR_W'(int'(c.wgt_base) + i % int'(c.chn));
            if (wgt_log[i] !== exp_addr) value_error("wgt_rd_addr", wgt_log[i], exp_addr);
        end
        if (wr_addr_log.size() != n_wr) begin
            other_error($sformatf("%0d output writes seen, %0d expected",
                                  wr_addr_log.size(), n_wr));
        end
        for (int i = 0; i < n_wr && i < wr_addr_log.size(); i++) begin
            exp_addr = ADDR_W'(int'(c.ofm_base) + i);
            exp_dat  = expected_row(c, i / NUM_ROW, i % NUM_ROW);
            if (wr_addr_log[i] !== exp_addr) value_error("ofm_wr_addr", wr_addr_log[i], exp_addr);
            if (wr_dat_log[i] !== exp_dat) value_error("ofm_wr_dat", wr_dat_log[i], exp_dat);
        end
        if (pend_act.size() != 0) other_error("read data still pending after the job");
    endtask

    // ========================================================================
    // Job driver and directed tests
    // ========================================================================
    task automatic run_job(input cfg_t c, input logic rand_mode, input logic pulse);
        int   n;
        int   n_wr;
        logic pulsed;
        logic early;
        if (timed_out) return;
        n_wr   = int'(c.num_grp) * NUM_ROW;
        pulsed = 1'b0;
        early  = 1'b0;
        act_log.delete();
        wgt_log.delete();
        wr_addr_log.delete();
        wr_dat_log.delete();
        rand_en  = rand_mode;
        cfg_info = c;
        cfg_vld  = 1'b1;
        for (n = 0; n < 50 && !cfg_rdy; n++) wait_cycle();
        if (!cfg_rdy) begin
            timeout("cfg_rdy before a new job");
            return;
        end
        wait_cycle();
        cfg_vld = 1'b0;
        for (n = 0; n < JOB_TIMEOUT && wr_addr_log.size() < n_wr; n++) begin
            if (cfg_rdy && !early) begin
                other_error("cfg_rdy rose before the last output write");
                early = 1'b1;
            end
            // A stray configuration while the job runs
            if (pulse && !pulsed && wr_addr_log.size() > 0) begin
                cfg_info = ~c;
                cfg_vld  = 1'b1;
                pulsed   = 1'b1;
            end else begin
                cfg_vld = 1'b0;
            end
            wait_cycle();
        end
        cfg_vld = 1'b0;
        if (wr_addr_log.size() < n_wr) begin
            timeout("the output writes of a job");
            return;
        end
        for (n = 0; n < 10 && !cfg_rdy; n++) wait_cycle();
        if (!cfg_rdy) begin
            timeout("cfg_rdy after the last write");
            return;
        end
        rand_en = 1'b0;
        check_job(c);
    endtask

    task automatic check_reset_values();
        if (cfg_rdy !== 1'b1) value_error("cfg_rdy", cfg_rdy, 1);
        if (act_rd_addr_vld !== 1'b0) value_error("act_rd_addr_vld", act_rd_addr_vld, 0);
        if (wgt_rd_addr_vld !== 1'b0) value_error("wgt_rd_addr_vld", wgt_rd_addr_vld, 0);
        if (act_rd_dat_rdy !== 1'b0) value_error("act_rd_dat_rdy", act_rd_dat_rdy, 0);
        if (wgt_rd_dat_rdy !== 1'b0) value_error("wgt_rd_dat_rdy", wgt_rd_dat_rdy, 0);
        if (ofm_wr_vld !== 1'b0) value_error("ofm_wr_vld", ofm_wr_vld, 0);
    endtask

    // With one channel each row is the ReLU of an outer product row
    task automatic single_group_outer_product();
        run_job(make_cfg('h0010, 'h0100, 'h4000, 1, 1, 0, 0), 1'b0, 1'b0);
    endtask

    task automatic three_groups_requant();
        run_job(make_cfg('h0080, 'h0300, 'h1230, 3, 6, 5, 'h21), 1'b0, 1'b0);
    endtask

    task automatic random_latency_job();
        run_job(make_cfg('h0080, 'h0300, 'h1230, 3, 6, 5, 'h21), 1'b1, 1'b0);
    endtask

    task automatic ignored_cfg_then_second_job();
        run_job(make_cfg('h0200, 'h0020, 'hff00, 2, 3, 3, 'h80), 1'b0, 1'b1);
        run_job(make_cfg('h0300, 'h0000, 'h0800, 4, 2, 2, 'h05), 1'b1, 1'b0);
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        cfg_vld         = 1'b0;
        cfg_info        = '0;
        act_rd_addr_rdy = 1'b0;
        wgt_rd_addr_rdy = 1'b0;
        act_rd_dat      = '0;
        act_rd_dat_vld  = 1'b0;
        wgt_rd_dat      = '0;
        wgt_rd_dat_vld  = 1'b0;
        ofm_wr_rdy      = 1'b0;
        rand_en         = 1'b0;
        rnd             = 1'b0;
        dly             = '0;
        timed_out       = 1'b0;
        n_val_err       = 0;
        n_oth_err       = 0;
        lfsr            = 32'h3d21a3b3;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            act_mem[i] = lfsr_bits(32);
            wgt_mem[i] = lfsr_bits(32);
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_reset_values();
        single_group_outer_product();
        three_groups_requant();
        random_latency_job();
        ignored_cfg_then_second_job();

        $display("value errors: %0d, other errors: %0d", n_val_err, n_oth_err);
        if (n_val_err == 0 && n_oth_err == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/sya_ctrl.sv
// Engine controller
// Configuration register, group loop FSM, channel and group counters
// Read address generation and read data handshake
`timescale 1ns/1ps
`default_nettype none

module sya_ctrl import sya_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_vld,
    output logic              cfg_rdy,
    input  cfg_t              cfg_info,
    output logic [ADDR_W-1:0] act_rd_addr,
    output logic              act_rd_addr_vld,
    input  logic              act_rd_addr_rdy,
    output logic [ADDR_W-1:0] wgt_rd_addr,
    output logic              wgt_rd_addr_vld,
    input  logic              wgt_rd_addr_rdy,
    input  logic              act_rd_dat_vld,
    input  logic              wgt_rd_dat_vld,
    output logic              rd_dat_rdy,
    output cfg_t              cfg,
    sya_ctrl_if.ctrl          ctl
);

    ctrl_state_t            state;
    ctrl_state_t            state_nxt;
    logic [CHN_W-1:0]       addr_cnt;
    logic [CHN_W-1:0]       beat_cnt;
    logic [GRP_W-1:0]       grp_cnt;
    logic [FLUSH_CNT_W-1:0] flush_cnt;
    logic                   cfg_acc;
    logic                   addr_vld;
    logic                   addr_acc;
    logic                   beat;
    logic                   load_done;
    logic                   flush_last;
    logic                   last_grp;

    // =========================================================================
    // Handshakes
    // =========================================================================
    assign cfg_rdy = state == S_IDLE;
    assign cfg_acc = cfg_vld && cfg_rdy;

    // Address pair is offered until chn pairs of this group are out
    assign addr_vld        = (state == S_LOAD) && (addr_cnt < cfg.chn);
    assign act_rd_addr_vld = addr_vld;
    assign wgt_rd_addr_vld = addr_vld;
    assign addr_acc        = addr_vld && act_rd_addr_rdy && wgt_rd_addr_rdy;

    assign act_rd_addr = cfg.act_base + ADDR_W'(grp_cnt) * ADDR_W'(cfg.chn)
                       + ADDR_W'(addr_cnt);
    assign wgt_rd_addr = cfg.wgt_base + ADDR_W'(addr_cnt);

    // Data may trail the addresses by any latency
    assign rd_dat_rdy = (state == S_LOAD) && (beat_cnt < cfg.chn);
    assign beat       = rd_dat_rdy && act_rd_dat_vld && wgt_rd_dat_vld;

    assign load_done  = (addr_cnt == cfg.chn) && (beat_cnt == cfg.chn);
    assign flush_last = flush_cnt == FLUSH_CNT_W'(FLUSH_STEPS - 1);
    assign last_grp   = grp_cnt == cfg.num_grp - GRP_W'(1);

    // Datapath control
    assign ctl.adv       = beat || (state == S_FLUSH);
    assign ctl.zero_in   = state == S_FLUSH;
    assign ctl.acc_clr   = state == S_CLEAR;
    assign ctl.drain_req = (state == S_FLUSH) && flush_last;
    assign ctl.drain_grp = grp_cnt;

    // =========================================================================
    // FSM
    // =========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:  if (cfg_acc)        state_nxt = S_LOAD;
            S_LOAD:  if (load_done)      state_nxt = S_FLUSH;
            S_FLUSH: if (flush_last)     state_nxt = S_DRAIN;
            S_DRAIN: if (ctl.drain_done) state_nxt = S_CLEAR;
            S_CLEAR: state_nxt = last_grp ? S_IDLE : S_LOAD;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cfg   <= '0;
        end else begin
            state <= state_nxt;
            if (cfg_acc) begin
                cfg <= cfg_info;
            end
        end
    end

    // =========================================================================
    // Counters
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt  <= '0;
            beat_cnt  <= '0;
            grp_cnt   <= '0;
            flush_cnt <= '0;
        end else begin
            // Channel counters restart for every group
            if (cfg_acc || state == S_CLEAR) begin
                addr_cnt <= '0;
                beat_cnt <= '0;
            end else begin
                if (addr_acc) begin
                    addr_cnt <= addr_cnt + 1'b1;
                end
                if (beat) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end

            if (state == S_FLUSH) begin
                flush_cnt <= flush_last ? '0 : flush_cnt + 1'b1;
            end

            if (cfg_acc) begin
                grp_cnt <= '0;
            end else if (state == S_CLEAR) begin
                grp_cnt <= grp_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/sya_ctrl_if.sv
// Control bundle from the controller to feeder, grid and output writer
`timescale 1ns/1ps
`default_nettype none

interface sya_ctrl_if import sya_pkg::*; ();

    // One systolic step for feeder and grid
    logic             adv;
    // Feeder takes zeros instead of memory data
    logic             zero_in;
    // Clear every accumulator before the next group
    logic             acc_clr;

    // Drain of one group, request and completion pulses
    logic             drain_req;
    logic [GRP_W-1:0] drain_grp;
    logic             drain_done;

    modport ctrl (
        output adv, zero_in, acc_clr, drain_req, drain_grp,
        input  drain_done
    );

    modport feed  (input adv, zero_in);

    modport array (input adv, acc_clr);

    modport drain (input drain_req, drain_grp, output drain_done);

endinterface

`default_nettype wire

// File: verilog/sya_feeder.sv
// Input skew for the systolic grid
// Activations enter the west edge, weights the north edge
`timescale 1ns/1ps
`default_nettype none

module sya_feeder import sya_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  act_vec_t act_rd_dat,
    input  wgt_vec_t wgt_rd_dat,
    sya_ctrl_if.feed ctl,
    output act_vec_t act_w,
    output wgt_vec_t wgt_n
);

    act_vec_t act_src;
    wgt_vec_t wgt_src;

    // Zeros during flush
    assign act_src = ctl.zero_in ? '0 : act_rd_dat;
    assign wgt_src = ctl.zero_in ? '0 : wgt_rd_dat;

    // Row r leaves r steps late
    for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
        if (r == 0) begin : g_pass
            assign act_w[r] = act_src[r];
        end else begin : g_dly
            act_t sr [r];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < r; i++) begin
                        sr[i] <= '0;
                    end
                end else if (ctl.adv) begin
                    sr[0] <= act_src[r];
                    for (int i = 1; i < r; i++) begin
                        sr[i] <= sr[i-1];
                    end
                end
            end

            assign act_w[r] = sr[r-1];
        end
    end

    // Column c leaves c steps late
    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        if (c == 0) begin : g_pass
            assign wgt_n[c] = wgt_src[c];
        end else begin : g_dly
            wgt_t sr [c];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < c; i++) begin
                        sr[i] <= '0;
                    end
                end else if (ctl.adv) begin
                    sr[0] <= wgt_src[c];
                    for (int i = 1; i < c; i++) begin
                        sr[i] <= sr[i-1];
                    end
                end
            end

            assign wgt_n[c] = sr[c-1];
        end
    end

endmodule

`default_nettype wire

// File: verilog/sya_ofm_writer.sv
// Output row drain
// ReLU and requantization per accumulator, output address, write handshake
`timescale 1ns/1ps
`default_nettype none

module sya_ofm_writer import sya_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  cfg_t              cfg,
    input  psum_mat_t         psum,
    sya_ctrl_if.drain         ctl,
    output ofm_vec_t          ofm_wr_dat,
    output logic [ADDR_W-1:0] ofm_wr_addr,
    output logic              ofm_wr_vld,
    input  logic              ofm_wr_rdy
);

    logic [ROW_CNT_W-1:0] row_cnt;
    logic                 wr_acc;
    logic                 last_row;

    // Negative sums clip to zero, others take ACT_W bits from bit shift up
    function automatic ofm_t requant(
        input acc_t               acc,
        input logic [SHIFT_W-1:0] shift,
        input logic [ACT_W-1:0]   zp
    );
        acc_t shifted;
        shifted = acc >>> shift;
        if (acc[ACC_W-1]) begin
            return '0;
        end
        return shifted[ACT_W-1:0] + zp;
    endfunction

    assign wr_acc         = ofm_wr_vld && ofm_wr_rdy;
    assign last_row       = row_cnt == ROW_CNT_W'(NUM_ROW - 1);
    assign ctl.drain_done = wr_acc && last_row;

    // Row r of group g lands at ofm_base + g*NUM_ROW + r
    assign ofm_wr_addr = cfg.ofm_base + ADDR_W'(ctl.drain_grp) * ADDR_W'(NUM_ROW)
                       + ADDR_W'(row_cnt);

    always_comb begin
        for (int c = 0; c < NUM_COL; c++) begin
            ofm_wr_dat[c] = requant(psum[row_cnt][c], cfg.shift, cfg.zp);
        end
    end

    // One write per row, held until accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld <= 1'b0;
            row_cnt    <= '0;
        end else if (ctl.drain_req) begin
            ofm_wr_vld <= 1'b1;
            row_cnt    <= '0;
        end else if (wr_acc) begin
            ofm_wr_vld <= !last_row;
            row_cnt    <= last_row ? '0 : row_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sya_pe.sv
// Processing element, signed multiply-accumulate
// Operands forwarded east and south one step later
`timescale 1ns/1ps
`default_nettype none

module sya_pe import sya_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic adv,
    input  logic acc_clr,
    input  act_t act_in,
    input  wgt_t wgt_in,
    output act_t act_out,
    output wgt_t wgt_out,
    output acc_t psum
);

    logic signed [ACT_W+WGT_W-1:0] prod;

    assign prod = act_in * wgt_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum    <= '0;
            act_out <= '0;
            wgt_out <= '0;
        end else if (acc_clr) begin
            psum    <= '0;
            act_out <= '0;
            wgt_out <= '0;
        end else if (adv) begin
            psum    <= psum + prod;
            act_out <= act_in;
            wgt_out <= wgt_in;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sya_pe_array.sv
// Output-stationary grid of NUM_ROW x NUM_COL processing elements
// Activations flow west to east, weights north to south
`timescale 1ns/1ps
`default_nettype none

module sya_pe_array import sya_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  act_vec_t  act_w,
    input  wgt_vec_t  wgt_n,
    sya_ctrl_if.array ctl,
    output psum_mat_t psum
);

    // Registered operands leaving each PE
    act_t act_e [NUM_ROW][NUM_COL];
    wgt_t wgt_s [NUM_ROW][NUM_COL];

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_r
        for (genvar c = 0; c < NUM_COL; c++) begin : g_c
            act_t a_in;
            wgt_t w_in;

            // West edge comes from the feeder
            if (c == 0) begin : g_a_edge
                assign a_in = act_w[r];
            end else begin : g_a_chain
                assign a_in = act_e[r][c-1];
            end

            // North edge comes from the feeder
            if (r == 0) begin : g_w_edge
                assign w_in = wgt_n[c];
            end else begin : g_w_chain
                assign w_in = wgt_s[r-1][c];
            end

            sya_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .adv     (ctl.adv),
                .acc_clr (ctl.acc_clr),
                .act_in  (a_in),
                .wgt_in  (w_in),
                .act_out (act_e[r][c]),
                .wgt_out (wgt_s[r][c]),
                .psum    (psum[r][c])
            );
        end
    end

endmodule

`default_nettype wire

// File: verilog/sya_pkg.sv
// Shared sizes and types of the systolic array engine
// Configuration word, operand vectors, accumulator matrix, controller states
`default_nettype none

package sya_pkg;

    // Array geometry
    localparam int NUM_ROW = 4;
    localparam int NUM_COL = 4;

    // Datapath widths
    localparam int ACT_W = 8;
    localparam int WGT_W = 8;
    localparam int ACC_W = 24;

    // Configuration field widths
    localparam int ADDR_W  = 16;
    localparam int CHN_W   = 8;
    localparam int GRP_W   = 8;
    localparam int SHIFT_W = 5;
    localparam int CFG_W   = 3 * ADDR_W + GRP_W + CHN_W + SHIFT_W + ACT_W;

    // Zero steps that push the last operands through skew and grid
    localparam int FLUSH_STEPS = NUM_ROW + NUM_COL - 1;
    localparam int FLUSH_CNT_W = $clog2(FLUSH_STEPS);
    localparam int ROW_CNT_W   = $clog2(NUM_ROW);

    // Scalar element types
    typedef logic signed [ACT_W-1:0] act_t;
    typedef logic signed [WGT_W-1:0] wgt_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic        [ACT_W-1:0] ofm_t;

    // Configuration word, most significant field first
    typedef struct packed {
        logic [ADDR_W-1:0]  act_base;
        logic [ADDR_W-1:0]  wgt_base;
        logic [ADDR_W-1:0]  ofm_base;
        logic [GRP_W-1:0]   num_grp;
        logic [CHN_W-1:0]   chn;
        logic [SHIFT_W-1:0] shift;
        logic [ACT_W-1:0]   zp;
    } cfg_t;

    // One memory beat per edge, element i belongs to row or column i
    typedef act_t [NUM_ROW-1:0] act_vec_t;
    typedef wgt_t [NUM_COL-1:0] wgt_vec_t;
    typedef ofm_t [NUM_COL-1:0] ofm_vec_t;

    typedef acc_t [NUM_ROW-1:0][NUM_COL-1:0] psum_mat_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_FLUSH,
        S_DRAIN,
        S_CLEAR
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/sya_top.sv
// Systolic array engine top level
// Controller, input skew feeder, 4x4 MAC grid and output row writer
`timescale 1ns/1ps
`default_nettype none

module sya_top import sya_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              cfg_vld,
    output logic              cfg_rdy,
    input  cfg_t              cfg_info,

    output logic [ADDR_W-1:0] act_rd_addr,
    output logic              act_rd_addr_vld,
    input  logic              act_rd_addr_rdy,
    output logic [ADDR_W-1:0] wgt_rd_addr,
    output logic              wgt_rd_addr_vld,
    input  logic              wgt_rd_addr_rdy,

    input  act_vec_t          act_rd_dat,
    input  logic              act_rd_dat_vld,
    output logic              act_rd_dat_rdy,
    input  wgt_vec_t          wgt_rd_dat,
    input  logic              wgt_rd_dat_vld,
    output logic              wgt_rd_dat_rdy,

    output ofm_vec_t          ofm_wr_dat,
    output logic [ADDR_W-1:0] ofm_wr_addr,
    output logic              ofm_wr_vld,
    input  logic              ofm_wr_rdy
);

    cfg_t      cfg;
    logic      rd_dat_rdy;
    act_vec_t  act_w;
    wgt_vec_t  wgt_n;
    psum_mat_t psum;

    sya_ctrl_if ctl_if ();

    // Both data channels share one ready
    assign act_rd_dat_rdy = rd_dat_rdy;
    assign wgt_rd_dat_rdy = rd_dat_rdy;

    sya_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_info        (cfg_info),
        .act_rd_addr     (act_rd_addr),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .rd_dat_rdy      (rd_dat_rdy),
        .cfg             (cfg),
        .ctl             (ctl_if.ctrl)
    );

    sya_feeder u_feeder (
        .clk        (clk),
        .rst_n      (rst_n),
        .act_rd_dat (act_rd_dat),
        .wgt_rd_dat (wgt_rd_dat),
        .ctl        (ctl_if.feed),
        .act_w      (act_w),
        .wgt_n      (wgt_n)
    );

    sya_pe_array u_pe_array (
        .clk   (clk),
        .rst_n (rst_n),
        .act_w (act_w),
        .wgt_n (wgt_n),
        .ctl   (ctl_if.array),
        .psum  (psum)
    );

    sya_ofm_writer u_ofm_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .psum        (psum),
        .ctl         (ctl_if.drain),
        .ofm_wr_dat  (ofm_wr_dat),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_rdy  (ofm_wr_rdy)
    );

endmodule

`default_nettype wire
